// File: src/icache_cfg_pkg.sv
package icache_cfg_pkg;

    localparam int TAG_W          = 19;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 5;   // byte offset inside a 32-byte line
    localparam int WORDS_PER_LINE = 8;
    localparam int NUM_SETS       = 256;

    // one fetch address, seen either whole or split for lookup
    typedef union packed {
        logic [31:0] raw;                    // exact byte address
        struct packed {
            logic [TAG_W-1:0]      tag;
            logic [INDEX_W-1:0]    index;
            logic [2:0]            word;     // word within the line
            logic [OFFSET_W-4:0]   byte_off;
        } f;
    } fetch_addr_u;

endpackage

// File: src/axi_rd_pkg.sv
package axi_rd_pkg;

    import icache_cfg_pkg::*;

    // arlen is beats minus one
    localparam logic [7:0] BURST_LEN_LINE   = 8'(WORDS_PER_LINE - 1);
    localparam logic [7:0] BURST_LEN_SINGLE = 8'd0;

    // arsize encoding, 2 means 4 bytes per beat
    localparam logic [2:0] BEAT_SIZE_WORD   = 3'd2;

endpackage

// File: src/icache_tag_ram.sv
module icache_tag_ram (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [icache_cfg_pkg::INDEX_W-1:0] rd_index,
    input  logic                             wr_en,
    input  logic [icache_cfg_pkg::INDEX_W-1:0] wr_index,
    input  logic [icache_cfg_pkg::TAG_W-1:0]   wr_tag,
    output logic [icache_cfg_pkg::TAG_W-1:0]   rd_tag,
    output logic                             rd_valid
);

    import icache_cfg_pkg::*;

    logic [TAG_W-1:0]    tag_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits;

    // tag storage, plain block ram
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
        rd_tag <= tag_mem[rd_index];
    end

    // valid flags live in flops so reset can wipe them
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            rd_valid   <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_bits[wr_index] <= 1'b1;
            end
            rd_valid <= valid_bits[rd_index]; // old value on same-index write
        end
    end

endmodule

// File: src/icache_data_bank.sv
module icache_data_bank (
    input  logic                                          clk,
    input  logic [icache_cfg_pkg::INDEX_W-1:0]              rd_index,
    input  logic [icache_cfg_pkg::WORDS_PER_LINE-1:0]       wr_en,
    input  logic [icache_cfg_pkg::INDEX_W-1:0]              wr_index,
    input  logic [31:0]                                   wr_data,
    output logic [icache_cfg_pkg::WORDS_PER_LINE-1:0][31:0] rd_line
);

    import icache_cfg_pkg::*;

    // one ram per word slot, all read at the same index
    for (genvar w = 0; w < WORDS_PER_LINE; w++) begin : g_bank
        logic [31:0] mem [NUM_SETS];

        always_ff @(posedge clk) begin
            if (wr_en[w]) begin
                mem[wr_index] <= wr_data;
            end
            rd_line[w] <= mem[rd_index];
        end
    end

endmodule

// File: src/icache_lru.sv
module icache_lru (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [icache_cfg_pkg::INDEX_W-1:0] index,
    input  logic                             lru_touch,
    input  logic                             touch_hit,
    input  logic                             hit_way,
    output logic                             victim_way
);

    import icache_cfg_pkg::*;

    // bit per set, value is the way to evict next
    logic [NUM_SETS-1:0] lru_bits;

    assign victim_way = lru_bits[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_bits <= '0;
        end else if (lru_touch) begin
            if (touch_hit) begin
                lru_bits[index] <= ~hit_way;          // other way goes next
            end else begin
                // fill went into the victim, so point at the other one
                lru_bits[index] <= ~lru_bits[index];
            end
        end
    end

endmodule

// File: src/icache_refill.sv
module icache_refill (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    refill_start,
    input  logic                                    line_mode,
    input  icache_cfg_pkg::fetch_addr_u             addr,
    // read channel
    output logic [31:0]                             araddr,
    output logic [7:0]                              arlen,
    output logic [2:0]                              arsize,
    output logic                                    arvalid,
    input  logic                                    arready,
    input  logic [31:0]                             rdata,
    input  logic                                    rlast,
    input  logic                                    rvalid,
    output logic                                    rready,
    // fill side
    output logic [icache_cfg_pkg::WORDS_PER_LINE-1:0] fill_wen,
    output logic [31:0]                             fill_word,
    output logic                                    refill_done,
    output logic [31:0]                             cap_word1,
    output logic [31:0]                             cap_word2
);

    import icache_cfg_pkg::*;
    import axi_rd_pkg::*;

    logic       mode_q;   // 1 = line burst, 0 = single uncached beat
    logic [2:0] cnt;      // beat number within the burst
    logic [2:0] next_word;
    logic       beat;

    assign beat      = rvalid & rready;
    assign next_word = addr.f.word + 3'd1;

    // address held by the requester, so these stay stable under arvalid
    assign araddr = mode_q ? {addr.f.tag, addr.f.index, {OFFSET_W{1'b0}}} : addr.raw;
    assign arlen  = mode_q ? BURST_LEN_LINE : BURST_LEN_SINGLE;
    assign arsize = BEAT_SIZE_WORD;

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            rready  <= 1'b0;
            mode_q  <= 1'b0;
            cnt     <= '0;
        end else begin
            if (refill_start) begin
                arvalid <= 1'b1;
                mode_q  <= line_mode;
                cnt     <= '0;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            if (beat) begin
                cnt <= cnt + 3'd1;   // only moves on a real transfer
                if (rlast) begin
                    rready <= 1'b0;
                end
            end
        end
    end

    // grab the requested words as they fly past
    always_ff @(posedge clk) begin
        if (beat && (!mode_q || cnt == addr.f.word)) begin
            cap_word1 <= rdata;
        end
        if (beat && mode_q && addr.f.word != 3'd7 && cnt == next_word) begin
            cap_word2 <= rdata;
        end
    end

    // one-hot strobe per beat, none for uncached
    always_comb begin
        fill_wen = '0;
        if (beat && mode_q) begin
            fill_wen[cnt] = 1'b1;
        end
    end

    assign fill_word   = rdata;
    assign refill_done = beat & rlast;

endmodule

// File: src/icache.sv
module icache (
    input  logic                        clk,
    input  logic                        rst,
    // fetch side
    input  logic                        req,
    input  logic                        uncached,
    input  icache_cfg_pkg::fetch_addr_u addr,
    output logic                        data_ok,
    output logic [31:0]                 rdata1,
    output logic [31:0]                 rdata2,
    output logic                        valid2,
    // read channel
    output logic [31:0]                 araddr,
    output logic [7:0]                  arlen,
    output logic [2:0]                  arsize,
    output logic                        arvalid,
    input  logic                        arready,
    input  logic [31:0]                 rdata,
    input  logic                        rlast,
    input  logic                        rvalid,
    output logic                        rready
);

    import icache_cfg_pkg::*;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL} state_t;

    state_t state;

    logic [TAG_W-1:0]                way_tag   [2];
    logic                            way_valid [2];
    logic [WORDS_PER_LINE-1:0][31:0] way_line  [2];
    logic [1:0]                      hit_vec;
    logic                            hit;
    logic [WORDS_PER_LINE-1:0][31:0] sel_line;

    logic                      refill_start;
    logic                      refill_done;
    logic                      done_q;
    logic [WORDS_PER_LINE-1:0] fill_wen;
    logic [31:0]               fill_word;
    logic [31:0]               cap_word1;
    logic [31:0]               cap_word2;
    logic                      victim_way;
    logic                      fill_way;   // victim latched for the whole refill
    logic                      lru_touch;

    // the RAMs always read at the live address, the held request makes it
    // the same index in IDLE and LOOKUP
    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_tag_ram u_tag (
            .clk      (clk),
            .rst      (rst),
            .rd_index (addr.f.index),
            .wr_en    (refill_done && !uncached && fill_way == 1'(w)),
            .wr_index (addr.f.index),
            .wr_tag   (addr.f.tag),
            .rd_tag   (way_tag[w]),
            .rd_valid (way_valid[w])
        );

        icache_data_bank u_data (
            .clk      (clk),
            .rd_index (addr.f.index),
            .wr_en    (fill_wen & {WORDS_PER_LINE{fill_way == 1'(w)}}),
            .wr_index (addr.f.index),
            .wr_data  (fill_word),
            .rd_line  (way_line[w])
        );

        assign hit_vec[w] = way_valid[w] && (way_tag[w] == addr.f.tag);
    end

    assign hit      = (|hit_vec) & ~uncached;   // uncached never looks at the tags
    assign sel_line = hit_vec[1] ? way_line[1] : way_line[0];

    icache_lru u_lru (
        .clk        (clk),
        .rst        (rst),
        .index      (addr.f.index),
        .lru_touch  (lru_touch),
        .touch_hit  (state == LOOKUP),
        .hit_way    (hit_vec[1]),
        .victim_way (victim_way)
    );

    assign lru_touch    = (state == LOOKUP && hit) || (refill_done && !uncached);
    assign refill_start = (state == LOOKUP) && !hit;

    icache_refill u_refill (
        .clk          (clk),
        .rst          (rst),
        .refill_start (refill_start),
        .line_mode    (~uncached),
        .addr         (addr),
        .araddr       (araddr),
        .arlen        (arlen),
        .arsize       (arsize),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .rready       (rready),
        .fill_wen     (fill_wen),
        .fill_word    (fill_word),
        .refill_done  (refill_done),
        .cap_word1    (cap_word1),
        .cap_word2    (cap_word2)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            done_q   <= 1'b0;
            fill_way <= 1'b0;
        end else begin
            done_q <= refill_done;   // captured words settle one cycle later
            if (refill_start) begin
                fill_way <= victim_way;
            end
            case (state)
                IDLE:    if (req) state <= LOOKUP;
                LOOKUP:  state <= hit ? IDLE : REFILL;
                REFILL:  if (done_q) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign data_ok = (state == LOOKUP && hit) || (state == REFILL && done_q);

    // second word only when it sits in the same line
    assign valid2 = ~uncached & (addr.f.word != 3'd7);

    always_comb begin
        if (state == LOOKUP) begin
            rdata1 = sel_line[addr.f.word];
            rdata2 = sel_line[3'(addr.f.word + 3'd1)];
        end else begin
            rdata1 = cap_word1;
            rdata2 = cap_word2;
        end
        if (!valid2) begin
            rdata2 = '0;
        end
    end

endmodule

// File: tb/axi_rom_model.sv
module axi_rom_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready
);

    integer      seed = 32'had7de591;
    logic        busy;
    logic [31:0] beat_addr;    // address of the next beat to offer
    logic [7:0]  beats_left;   // beats after the current one

    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rdata   <= '0;
            busy    <= 1'b0;
        end else if (!busy) begin
            arready <= ($random(seed) & 32'h3) != 32'h0;   // stalls about one cycle in four
            if (arvalid && arready) begin
                busy       <= 1'b1;
                arready    <= 1'b0;
                beat_addr  <= araddr;
                beats_left <= arlen;
            end
        end else if (rvalid && rready) begin
            // beat taken, always at least one idle cycle before the next
            rvalid <= 1'b0;
            rlast  <= 1'b0;
            if (rlast) begin
                busy <= 1'b0;
            end else begin
                beat_addr  <= beat_addr + 32'd4;
                beats_left <= beats_left - 8'd1;
            end
        end else if (!rvalid && (($random(seed) & 32'h3) != 32'h0)) begin
            rvalid <= 1'b1;
            rdata  <= beat_addr ^ 32'h5a5a_0000;   // rom contents
            rlast  <= beats_left == 8'd0;
        end
    end

endmodule

// File: tb/icache_tb.sv
module icache_tb;

    localparam int          CLK_PERIOD     = 100;
    localparam int          NUM_ROWS       = 17;
    localparam int          HIT_REQ_CYCLES = 2;   // IDLE cycle plus LOOKUP cycle
    localparam logic [31:0] DATA_XOR       = 32'h5a5a_0000;

    typedef struct packed {
        logic [31:0] addr;
        logic        unc;
        logic        v2;         // second word expected
        int          ar_delta;   // address handshakes this row causes
    } row_t;

    logic clk, rst, req, uncached, data_ok, valid2;
    icache_cfg_pkg::fetch_addr_u addr;
    logic [31:0] rdata1, rdata2, araddr, rdata;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic        arvalid, arready, rlast, rvalid, rready;

    row_t        rows [NUM_ROWS];
    int          errors = 0;
    int          failed_rows = 0;
    int          cur_row = 0;
    int          ar_count = 0;
    logic [31:0] last_araddr;
    logic [7:0]  last_arlen;
    logic [2:0]  last_arsize;

    icache uut (.*);
    axi_rom_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_ROWS * 400 * CLK_PERIOD);
        $display("timeout: the cache gave no data_ok for row %0d", cur_row);
        $display("Test FAILED");
        $finish;
    end

    // count address handshakes in the middle of the cycle
    always @(negedge clk) begin
        if (!rst && arvalid && arready) begin
            ar_count    <= ar_count + 1;
            last_araddr <= araddr;
            last_arlen  <= arlen;
            last_arsize <= arsize;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail row %0d %s got %h expected %h", cur_row, name, got, exp);
        errors++;
    endtask

    // set 5 holds tags A (0x10), B (0x30), C (0x40)
    task automatic load_table();
        rows[0]  = '{32'h0002_00a4, 1'b0, 1'b1, 1};   // cold miss on A
        rows[1]  = '{32'h0002_00b0, 1'b0, 1'b1, 0};
        rows[2]  = '{32'h0002_00a4, 1'b0, 1'b1, 0};
        rows[3]  = '{32'h0002_00bc, 1'b0, 1'b0, 0};   // last word, hit
        rows[4]  = '{32'h0004_01fc, 1'b0, 1'b0, 1};   // last word, miss
        rows[5]  = '{32'h0006_00a0, 1'b0, 1'b1, 1};   // B fills the other way
        rows[6]  = '{32'h0002_00a8, 1'b0, 1'b1, 0};
        rows[7]  = '{32'h0008_00a0, 1'b0, 1'b1, 1};   // C evicts B
        rows[8]  = '{32'h0002_00b8, 1'b0, 1'b1, 0};
        rows[9]  = '{32'h0006_00a4, 1'b0, 1'b1, 1};   // B is gone
        rows[10] = '{32'h000a_0134, 1'b1, 1'b0, 1};
        rows[11] = '{32'h000a_0134, 1'b0, 1'b1, 1};   // uncached left no line behind
        rows[12] = '{32'h000a_0138, 1'b0, 1'b1, 0};
        rows[13] = '{32'h0002_00ac, 1'b1, 1'b0, 1};   // uncached over a cached line
        rows[14] = '{32'h0002_00ac, 1'b0, 1'b1, 0};
        rows[15] = '{32'h0010_0f00, 1'b0, 1'b1, 1};
        rows[16] = '{32'h0010_0f1c, 1'b0, 1'b0, 0};
    endtask

    task automatic run_row(input int i);
        row_t        r;
        int          ar_before;
        int          cycles;
        int          errs_before;
        logic [31:0] exp1;
        logic [31:0] exp2;
        logic [31:0] exp_araddr;
        logic [31:0] exp_arlen;
        r           = rows[i];
        cur_row     = i;
        errs_before = errors;
        ar_before   = ar_count;
        exp1        = r.addr ^ DATA_XOR;
        exp2        = (r.addr + 32'd4) ^ DATA_XOR;
        exp_araddr  = r.unc ? r.addr : {r.addr[31:5], 5'd0};
        exp_arlen   = r.unc ? 32'd0 : 32'd7;
        @(negedge clk);
        req      = 1'b1;
        uncached = r.unc;
        addr.raw = r.addr;
        cycles   = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!data_ok);
        assert (rdata1 == exp1) else report_mismatch("rdata1", rdata1, exp1);
        assert (valid2 == r.v2) else report_mismatch("valid2", 32'(valid2), 32'(r.v2));
        if (r.v2) begin
            assert (rdata2 == exp2) else report_mismatch("rdata2", rdata2, exp2);
        end
        // the burst is over by the time the words come back
        assert (rready == 1'b0) else report_mismatch("rready", 32'(rready), 32'd0);
        assert (ar_count - ar_before == r.ar_delta)
            else report_mismatch("ar handshakes", 32'(ar_count - ar_before), 32'(r.ar_delta));
        if (r.ar_delta == 1) begin
            assert (last_araddr == exp_araddr)
                else report_mismatch("araddr", last_araddr, exp_araddr);
            assert (32'(last_arlen) == exp_arlen)
                else report_mismatch("arlen", 32'(last_arlen), exp_arlen);
            assert (last_arsize == 3'd2) else report_mismatch("arsize", 32'(last_arsize), 32'd2);
        end else begin
            assert (cycles + 1 == HIT_REQ_CYCLES)
                else report_mismatch("hit latency", 32'(cycles + 1), 32'(HIT_REQ_CYCLES));
        end
        @(negedge clk);
        req = 1'b0;   // drop in the cycle after data_ok
        if (errors == errs_before) begin
            $display("row %0d addr %h: ok, %0d cycles", i, r.addr, cycles + 1);
        end else begin
            $display("row %0d addr %h: failed", i, r.addr);
            failed_rows++;
        end
    endtask

    initial begin
        rst      = 1'b1;
        req      = 1'b0;
        uncached = 1'b0;
        addr.raw = '0;
        load_table();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("%0d rows, %0d passed, %0d failed, %0d errors", NUM_ROWS,
                 NUM_ROWS - failed_rows, failed_rows, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
src/icache_cfg_pkg.sv
src/axi_rd_pkg.sv
src/icache_tag_ram.sv
src/icache_data_bank.sv
src/icache_lru.sv
src/icache_refill.sv
src/icache.sv
tb/axi_rom_model.sv
tb/icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module icache_tb -f sources.f -o icache_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/icache_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
